// File: verilog/histogram_params.svh
`ifndef HISTOGRAM_PARAMS_SVH
`define HISTOGRAM_PARAMS_SVH

// timestamp width in bits
`define NP 12

// bin index width, 2^NB bins per pixel
`define NB 4

`define PIXEL_NUM 4 // pixels sharing the histogram
`define DATA_NUM 8  // samples per pixel per acquisition
`define ACQ_NUM 2   // acquisitions per pass

// bin count width, must hold DATA_NUM * ACQ_NUM
`define PEAK_MAX 8

`endif

// File: verilog/histogramPkg.sv
`include "histogram_params.svh"

package histogramPkg;

    // one timestamp from a pixel
    typedef logic [`NP-1:0] timeT;

    // bin index within one pixel histogram
    typedef logic [`NB-1:0] binT;

    typedef logic [1:0] pixelT; // covers PIXEL_NUM = 4

    // hit count of a single bin
    typedef logic [`PEAK_MAX-1:0] countT;

    // coarse pass uses top bits, fine pass uses the window
    typedef enum logic {
        COARSE = 1'b0,
        FINE   = 1'b1
    } passT;

endpackage

// File: verilog/sampleBinner.sv
`timescale 1ns/10ps
`include "histogram_params.svh"

module sampleBinner (
    input  logic                clk,
    input  logic                combin_res,
    input  logic                wrEn,
    input  histogramPkg::timeT  data,
    input  logic                busy,
    input  logic                winLoad,
    input  histogramPkg::pixelT winPixel,
    input  histogramPkg::timeT  winLower,
    output logic                binWr,
    output histogramPkg::pixelT binPixel,
    output histogramPkg::binT   binAddr,
    output logic                passStart,
    output logic                passEnd,
    output histogramPkg::passT  pass
);
    import histogramPkg::*;

    localparam int IW = $clog2(`DATA_NUM);
    localparam int AW = $clog2(`ACQ_NUM);
    localparam logic [IW-1:0] IN_LAST = IW'(`DATA_NUM - 1);
    localparam logic [AW-1:0] ACQ_LAST = AW'(`ACQ_NUM - 1);
    localparam pixelT PIX_LAST = pixelT'(`PIXEL_NUM - 1);

    logic [IW-1:0] inCnt; // sample within pixel
    pixelT pixCnt;
    logic [AW-1:0] acqCnt;
    timeT winReg [`PIXEL_NUM]; // fine window lower edge per pixel
    logic waitReport; // pass finished, waiting for the report to start
    logic accept;
    logic firstSmp;
    logic lastSmp;
    logic inWin;
    timeT diff;

    // hold off from the last sample until the report begins
    assign accept = wrEn && !busy && !waitReport;
    assign firstSmp = (inCnt == '0) && (pixCnt == '0) && (acqCnt == '0);
    assign lastSmp = (inCnt == IN_LAST) && (pixCnt == PIX_LAST) && (acqCnt == ACQ_LAST);

    // below the edge wraps to a large value, so one compare is enough
    assign diff = data - winReg[pixCnt];
    assign inWin = (diff[`NP-1:`NB] == '0);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            inCnt <= '0;
            pixCnt <= '0;
            acqCnt <= '0;
            pass <= COARSE;
            waitReport <= 1'b0;
            binWr <= 1'b0;
            passStart <= 1'b0;
            passEnd <= 1'b0;
            for (int i = 0; i < `PIXEL_NUM; i++) begin
                winReg[i] <= '0;
            end
        end else begin
            binWr <= accept && ((pass == COARSE) || inWin); // out of window is consumed
            passStart <= accept && firstSmp;
            passEnd <= accept && lastSmp;

            if (accept) begin
                if (inCnt == IN_LAST) begin
                    inCnt <= '0;
                    if (pixCnt == PIX_LAST) begin
                        pixCnt <= '0;
                        acqCnt <= (acqCnt == ACQ_LAST) ? '0 : acqCnt + 1'b1;
                    end else begin
                        pixCnt <= pixCnt + 1'b1;
                    end
                end else begin
                    inCnt <= inCnt + 1'b1;
                end
            end

            // flip the pass once the tracker has taken the finished one
            if (accept && lastSmp) begin
                waitReport <= 1'b1;
            end else if (waitReport && busy) begin
                waitReport <= 1'b0;
                pass <= (pass == COARSE) ? FINE : COARSE;
            end

            if (winLoad) begin
                winReg[winPixel] <= winLower;
            end
        end
    end

    always_ff @(posedge clk) begin
        binPixel <= pixCnt;
        binAddr <= (pass == COARSE) ? data[`NP-1 -: `NB] : diff[`NB-1:0]; // fine bin is offset
    end

    // samples are blocked across the whole report, including the lead-in cycles
    assert property (@(posedge clk) disable iff (!combin_res) busy |-> !$rose(binWr));

endmodule

// File: verilog/binMemory.sv
`timescale 1ns/10ps
`include "histogram_params.svh"

module binMemory (
    input  logic                clk,
    input  logic                combin_res,
    input  logic                binWr,
    input  histogramPkg::pixelT binPixel,
    input  histogramPkg::binT   binAddr,
    input  logic                passStart,
    input  logic                passEnd,
    output logic                updValid,
    output histogramPkg::pixelT updPixel,
    output histogramPkg::binT   updBin,
    output histogramPkg::countT updCount,
    output logic                passDone
);
    import histogramPkg::*;

    localparam int DEPTH = `PIXEL_NUM * (1 << `NB);
    localparam int AW = $clog2(DEPTH);
    localparam countT COUNT_MAX = countT'(`DATA_NUM * `ACQ_NUM);

    countT cntRam [DEPTH]; // pixel-major, one histogram after another
    logic [DEPTH-1:0] vld;
    logic [DEPTH-1:0] vldNext;
    logic [AW-1:0] idx;
    countT curCnt;
    countT newCnt;

    assign idx = {binPixel, binAddr};

    // a stale entry reads as zero, also in the cycle that starts a pass
    always_comb begin
        curCnt = (vld[idx] && !passStart) ? cntRam[idx] : '0;
        newCnt = curCnt + 1'b1;
    end

    always_comb begin
        vldNext = passStart ? '0 : vld;
        if (binWr) begin
            vldNext[idx] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            vld <= '0;
            updValid <= 1'b0;
            passDone <= 1'b0;
        end else begin
            vld <= vldNext;
            updValid <= binWr;
            passDone <= passEnd; // lines up with the last update
        end
    end

    // write and read-back in one cycle, so back-to-back hits chain
    always_ff @(posedge clk) begin
        if (binWr) begin
            cntRam[idx] <= newCnt;
            updPixel <= binPixel;
            updBin <= binAddr;
            updCount <= newCnt;
        end
    end

    // holds only if the binner clears the bins at every pass start
    assert property (@(posedge clk) disable iff (!combin_res)
        updValid |-> (updCount <= COUNT_MAX));

endmodule

// File: verilog/peakTracker.sv
`timescale 1ns/10ps
`include "histogram_params.svh"

module peakTracker (
    input  logic                clk,
    input  logic                combin_res,
    input  logic                updValid,
    input  histogramPkg::pixelT updPixel,
    input  histogramPkg::binT   updBin,
    input  histogramPkg::countT updCount,
    input  logic                passDone,
    input  histogramPkg::passT  pass,
    output logic                busy,
    output logic                winLoad,
    output histogramPkg::pixelT winPixel,
    output histogramPkg::timeT  winLower,
    output logic                peakValid,
    output histogramPkg::pixelT peakPixel,
    output histogramPkg::timeT  peakTime,
    output histogramPkg::passT  peakPass
);
    import histogramPkg::*;

    localparam timeT HALF = timeT'(1 << (`NB - 1));
    localparam timeT TMAX = '1;
    localparam timeT UPPER = timeT'((1 << `NP) - (1 << `NB)); // highest legal lower edge
    localparam pixelT PIX_LAST = pixelT'(`PIXEL_NUM - 1);

    countT maxCnt [`PIXEL_NUM];
    binT peakBin [`PIXEL_NUM];
    timeT winCopy [`PIXEL_NUM]; // same windows as the binner holds
    pixelT repPix;
    passT repPass; // pass being reported
    timeT centre;

    // window around the coarse peak, clamped at both ends of the range
    always_comb begin
        centre = {peakBin[repPix], {(`NP - `NB){1'b0}}};
        if (centre <= HALF) begin
            winLower = '0;
        end else if (centre >= TMAX - HALF) begin
            winLower = UPPER;
        end else begin
            winLower = centre - HALF;
        end
    end

    assign peakValid = busy;
    assign peakPixel = repPix;
    assign peakPass = repPass;
    assign peakTime = (repPass == COARSE) ? centre : winCopy[repPix] + timeT'(peakBin[repPix]);
    assign winLoad = busy && (repPass == COARSE);
    assign winPixel = repPix;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            busy <= 1'b0;
            repPix <= '0;
            repPass <= COARSE;
            for (int i = 0; i < `PIXEL_NUM; i++) begin
                maxCnt[i] <= '0;
                peakBin[i] <= '0;
                winCopy[i] <= '0;
            end
        end else if (busy) begin
            maxCnt[repPix] <= '0; // ready for the next pass
            peakBin[repPix] <= '0;
            if (winLoad) begin
                winCopy[repPix] <= winLower;
            end
            if (repPix == PIX_LAST) begin
                busy <= 1'b0;
                repPix <= '0;
            end else begin
                repPix <= repPix + 1'b1;
            end
        end else begin
            if (passDone) begin
                busy <= 1'b1;
                repPass <= pass;
            end
            // strictly greater, so the earliest bin keeps a tie
            if (updValid && (updCount > maxCnt[updPixel])) begin
                maxCnt[updPixel] <= updCount;
                peakBin[updPixel] <= updBin;
            end
        end
    end

    // the binner must hold samples back for the whole report
    assert property (@(posedge clk) disable iff (!combin_res) busy |-> !updValid);

endmodule

// File: verilog/histogramTop.sv
`timescale 1ns/10ps

module histogramTop (
    input  logic                clk,
    input  logic                combin_res,
    input  logic                wrEn,
    input  histogramPkg::timeT  data,
    output logic                busy,
    output logic                peakValid,
    output histogramPkg::pixelT peakPixel,
    output histogramPkg::timeT  peakTime,
    output histogramPkg::passT  peakPass
);
    import histogramPkg::*;

    logic binWr;
    pixelT binPixel;
    binT binAddr;
    logic passStart;
    logic passEnd;
    passT pass;
    logic updValid;
    pixelT updPixel;
    binT updBin;
    countT updCount;
    logic passDone;
    logic winLoad; // window feedback to the binner
    pixelT winPixel;
    timeT winLower;

    sampleBinner u_sampleBinner (
        .clk       (clk),
        .combin_res(combin_res),
        .wrEn      (wrEn),
        .data      (data),
        .busy      (busy),
        .winLoad   (winLoad),
        .winPixel  (winPixel),
        .winLower  (winLower),
        .binWr     (binWr),
        .binPixel  (binPixel),
        .binAddr   (binAddr),
        .passStart (passStart),
        .passEnd   (passEnd),
        .pass      (pass)
    );

    binMemory u_binMemory (
        .clk       (clk),
        .combin_res(combin_res),
        .binWr     (binWr),
        .binPixel  (binPixel),
        .binAddr   (binAddr),
        .passStart (passStart),
        .passEnd   (passEnd),
        .updValid  (updValid),
        .updPixel  (updPixel),
        .updBin    (updBin),
        .updCount  (updCount),
        .passDone  (passDone)
    );

    peakTracker u_peakTracker (
        .clk       (clk),
        .combin_res(combin_res),
        .updValid  (updValid),
        .updPixel  (updPixel),
        .updBin    (updBin),
        .updCount  (updCount),
        .passDone  (passDone),
        .pass      (pass),
        .busy      (busy),
        .winLoad   (winLoad),
        .winPixel  (winPixel),
        .winLower  (winLower),
        .peakValid (peakValid),
        .peakPixel (peakPixel),
        .peakTime  (peakTime),
        .peakPass  (peakPass)
    );

endmodule

// File: testbench/histogramTb.sv
`timescale 1ns/10ps
`include "histogram_params.svh"

module histogramTb;
    import histogramPkg::*;

    localparam int PASS_SMP = `PIXEL_NUM * `DATA_NUM * `ACQ_NUM;
    localparam int PASS_NUM = 12; // passes run by all tests together
    localparam int PASS_OVERHEAD = 20; // dropped strobes, report and idle per pass
    localparam int LIMIT_CYC = 16 + 20 + PASS_NUM * (PASS_SMP + PASS_OVERHEAD) + 200;

    logic clk;
    logic combin_res;
    logic wrEn;
    timeT data;
    logic busy;
    logic peakValid;
    pixelT peakPixel;
    timeT peakTime;
    passT peakPass;

    int expQ[$]; // {pass, pixel, time} of each expected report
    int expItem;
    int cntM [`PIXEL_NUM][1 << `NB];
    int maxM [`PIXEL_NUM];
    int pkM [`PIXEL_NUM];
    int winM [`PIXEL_NUM]; // fine window lower edges
    passT passM;
    int coarseBin [`PIXEL_NUM] = '{0, 15, 7, 10};
    int fineOff [`PIXEL_NUM] = '{3, 12, 0, 15};

    histogramTop u_histogramTop (
        .clk       (clk),
        .combin_res(combin_res),
        .wrEn      (wrEn),
        .data      (data),
        .busy      (busy),
        .peakValid (peakValid),
        .peakPixel (peakPixel),
        .peakTime  (peakTime),
        .peakPass  (peakPass)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abortRun(string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic checkValue(string name, logic [31:0] expV, logic [31:0] actV);
        if (actV !== expV) begin
            abortRun($sformatf("** Error at %0t: %s expected %0d, got %0d",
                $time, name, expV, actV));
        end
    endtask

    function automatic int lowerEdge(int pk);
        int centre;
        int half;
        centre = pk << (`NP - `NB);
        half = 1 << (`NB - 1);
        if (centre <= half) begin
            return 0;
        end else if (centre >= (1 << `NP) - 1 - half) begin
            return (1 << `NP) - (1 << `NB); // clamp at full scale
        end
        return centre - half;
    endfunction

    function automatic timeT makeSample(int mode, int p, int i);
        int w;
        timeT r;
        w = winM[p];
        r = $urandom;
        case (mode)
            1: return (i < 5) ? timeT'((coarseBin[p] << (`NP - `NB)) | (r & 255)) : r;
            2: begin
                if (i < 4) return timeT'(w + fineOff[p]);
                else if (i < 6) return timeT'(w + (r & 15));
                else return timeT'(w + 16 + r % 1000); // outside the window
            end
            3: return timeT'((((i % 2) == (p % 2)) ? p + 2 : p + 9) << (`NP - `NB) | (r & 255));
            4: begin
                if (p == 3) return timeT'(w + 16 + r % 1000); // pixel left empty
                return timeT'(w + (((i % 2) == 0) ? p + 1 : p + 7));
            end
            default: return (passM == FINE && (i % 2) == 0) ? timeT'(w + (r & 15)) : r;
        endcase
    endfunction

    task automatic modelSample(int p, timeT d);
        int bin;
        int diff;
        bit counted;
        if (passM == COARSE) begin
            bin = d >> (`NP - `NB);
            counted = 1'b1;
        end else begin
            diff = (int'(d) - winM[p] + (1 << `NP)) % (1 << `NP);
            counted = diff < (1 << `NB);
            bin = diff;
        end
        if (counted) begin
            cntM[p][bin]++;
            if (cntM[p][bin] > maxM[p]) begin // strictly greater keeps the earlier bin on a tie
                maxM[p] = cntM[p][bin];
                pkM[p] = bin;
            end
        end
    endtask

    task automatic modelPassEnd();
        int t;
        for (int p = 0; p < `PIXEL_NUM; p++) begin
            if (passM == COARSE) t = pkM[p] << (`NP - `NB);
            else t = (winM[p] + pkM[p]) % (1 << `NP);
            expQ.push_back((int'(passM) << 14) | (p << 12) | t);
            if (passM == COARSE) winM[p] = lowerEdge(pkM[p]);
            maxM[p] = 0;
            pkM[p] = 0;
            for (int b = 0; b < (1 << `NB); b++) cntM[p][b] = 0;
        end
        passM = (passM == COARSE) ? FINE : COARSE;
    endtask

    task automatic waitReports();
        while (expQ.size() != 0 || busy) @(negedge clk);
    endtask

    // one full pass in arrival order with optional strobes during the report
    task automatic runPass(int mode, bit junk);
        timeT d;
        for (int a = 0; a < `ACQ_NUM; a++) begin
            for (int p = 0; p < `PIXEL_NUM; p++) begin
                for (int i = 0; i < `DATA_NUM; i++) begin
                    @(posedge clk);
                    #1;
                    d = makeSample(mode, p, i);
                    wrEn = 1'b1;
                    data = d;
                    modelSample(p, d);
                end
            end
        end
        modelPassEnd();
        if (junk) begin
            for (int k = 1; k <= 6; k++) begin // lead-in plus report cycles
                @(posedge clk);
                #1;
                if (k == 4) checkValue("busy", 1, busy);
                data = $urandom;
            end
        end
        @(posedge clk);
        #1;
        wrEn = 1'b0;
        waitReports();
    endtask

    task automatic testResetState();
        repeat (20) begin
            @(negedge clk);
            checkValue("busy", 0, busy);
            checkValue("peakValid", 0, peakValid);
        end
        runPass(0, 1'b0); // coarse
        runPass(0, 1'b0);
    endtask

    task automatic testCoarsePeaks();
        runPass(1, 1'b0);
    endtask

    task automatic testFineWindows();
        runPass(2, 1'b0); // windows at 0, top of range and mid
    endtask

    task automatic testTiesAndEmpty();
        runPass(3, 1'b0);
        runPass(4, 1'b0);
    endtask

    task automatic testBusyDrop();
        runPass(0, 1'b1);
        runPass(0, 1'b1);
    endtask

    task automatic testPassAlternation();
        repeat (4) runPass(0, 1'b0);
    endtask

    // reports are stable between edges
    always @(negedge clk) begin
        if (combin_res && peakValid) begin
            if (expQ.size() == 0) begin
                abortRun("peakValid pulsed while no report was expected");
            end else begin
                expItem = expQ.pop_front();
                checkValue("peakPass", expItem >> 14, peakPass);
                checkValue("peakPixel", (expItem >> 12) & 3, peakPixel);
                checkValue("peakTime", expItem & 12'hfff, peakTime);
            end
        end
    end

    initial begin
        #(LIMIT_CYC * 10);
        abortRun("timeout, the expected peak reports did not arrive");
    end

    initial begin
        void'($urandom(57));
        combin_res = 1'b0;
        wrEn = 1'b0;
        data = '0;
        passM = COARSE;
        for (int p = 0; p < `PIXEL_NUM; p++) begin
            winM[p] = 0;
            maxM[p] = 0;
            pkM[p] = 0;
            for (int b = 0; b < (1 << `NB); b++) cntM[p][b] = 0;
        end
        repeat (16) @(posedge clk);
        #1;
        combin_res = 1'b1;
        testResetState();
        testCoarsePeaks();
        testFineWindows();
        testTiesAndEmpty();
        testBusyDrop();
        testPassAlternation();
        repeat (5) @(negedge clk); // a stray report would still reach the monitor here
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: all.f
+incdir+verilog
verilog/histogramPkg.sv
verilog/sampleBinner.sv
verilog/binMemory.sv
verilog/peakTracker.sv
verilog/histogramTop.sv
testbench/histogramTb.sv

// File: Bender.yml
package:
  name: histogram

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/histogramPkg.sv
      - verilog/sampleBinner.sv
      - verilog/binMemory.sv
      - verilog/peakTracker.sv
      - verilog/histogramTop.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - testbench/histogramTb.sv
